// File: design/serial_pkg.sv
`default_nettype none

package serial_pkg;

   typedef enum logic [3:0] {
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_ADDI,
      OP_LW,
      OP_SW,
      OP_ILLEGAL
   } op_e;

   typedef enum logic [2:0] {
      ST_WAIT_INSN,
      ST_DECODE,
      ST_EXEC,
      ST_MEM,
      ST_LOAD_WB,
      ST_RETIRE
   } ctrl_state_e;

   typedef enum logic {
      OWN_FETCH,
      OWN_LSU
   } bus_owner_e;

   typedef struct packed {
      op_e         op;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] imm;
   } dec_t;

   // Word address, byte lanes are not supported
   typedef struct packed {
      logic [29:0] addr;
      logic        we;
      logic [31:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic [31:0] rdata;
   } mem_rsp_t;

endpackage

`default_nettype wire

// File: design/serial_alu.sv
`timescale 1ns/1ps
`default_nettype none

module serial_alu
   import serial_pkg::*;
(
   input  wire       clk,
   input  wire       i_rst_n,
   input  wire       i_exec,
   input  wire [4:0] i_cnt,
   input  wire op_e  i_op,
   input  wire       i_rs1_bit,
   input  wire       i_opb_bit,
   output logic      o_rd_bit
);

   logic carry_q;
   logic opb;
   logic cin;
   logic sum;

   // Subtract as a + ~b + 1
   assign opb = (i_op == OP_SUB) ? !i_opb_bit : i_opb_bit;
   assign cin = (i_cnt == 5'd0) ? (i_op == OP_SUB) : carry_q;
   assign sum = i_rs1_bit ^ opb ^ cin;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (i_exec) begin
         carry_q <= (i_rs1_bit & opb) | (cin & (i_rs1_bit ^ opb));
      end
   end

   always_comb begin
      case (i_op)
         OP_AND:  o_rd_bit = i_rs1_bit & i_opb_bit;
         OP_OR:   o_rd_bit = i_rs1_bit | i_opb_bit;
         OP_XOR:  o_rd_bit = i_rs1_bit ^ i_opb_bit;
         default: o_rd_bit = sum;
      endcase
   end

endmodule

`default_nettype wire

// File: design/serial_rf.sv
`timescale 1ns/1ps
`default_nettype none

module serial_rf (
   input  wire       clk,
   input  wire       i_rst_n,
   input  wire [4:0] i_cnt,
   input  wire [4:0] i_rs1,
   input  wire [4:0] i_rs2,
   input  wire [4:0] i_rd,
   input  wire       i_wen,
   input  wire       i_wbit,
   output logic      o_rs1_bit,
   output logic      o_rs2_bit
);

   logic [31:0] regs_q [32];

   // Bit written at the edge, so a same-cycle read sees the old bit
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs_q[i] <= 32'd0;
         end
      end else if (i_wen) begin
         regs_q[i_rd][i_cnt] <= i_wbit;
      end
   end

   assign o_rs1_bit = regs_q[i_rs1][i_cnt];
   assign o_rs2_bit = regs_q[i_rs2][i_cnt];

   // x0 stays zero only through the write gating in control
   assert property (@(posedge clk) disable iff (!i_rst_n) i_wen |-> (i_rd != 5'd0));

endmodule

`default_nettype wire

// File: design/serial_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module serial_ctrl
   import serial_pkg::*;
(
   input  wire        clk,
   input  wire        i_rst_n,
   input  wire [31:0] i_insn,
   input  wire        i_insn_valid,
   input  wire        i_lsu_done,
   input  wire        i_rs2_bit,
   output logic       o_insn_take,
   output dec_t       o_dec,
   output logic [4:0] o_cnt,
   output logic       o_exec,
   output logic       o_load_wb,
   output logic       o_mem_go,
   output logic       o_opb_bit,
   output logic       o_rd_wen,
   output logic       o_retire,
   output logic       o_retire_illegal
);

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   dec_t        dec_w;
   dec_t        dec_q;
   logic [4:0]  cnt_q;
   logic        go_q;
   logic        last_bit;
   logic        is_mem;
   logic        is_reg_op;

   always_comb begin
      dec_w.op  = OP_ILLEGAL;
      dec_w.rd  = i_insn[11:7];
      dec_w.rs1 = i_insn[19:15];
      dec_w.rs2 = i_insn[24:20];
      dec_w.imm = {{20{i_insn[31]}}, i_insn[31:20]};
      case (i_insn[6:0])
         7'b0110011: begin
            // funct7 and funct3 together
            case ({i_insn[31:25], i_insn[14:12]})
               10'b0000000_000: dec_w.op = OP_ADD;
               10'b0100000_000: dec_w.op = OP_SUB;
               10'b0000000_100: dec_w.op = OP_XOR;
               10'b0000000_110: dec_w.op = OP_OR;
               10'b0000000_111: dec_w.op = OP_AND;
               default:         dec_w.op = OP_ILLEGAL;
            endcase
         end
         7'b0010011: if (i_insn[14:12] == 3'b000) dec_w.op = OP_ADDI;
         7'b0000011: if (i_insn[14:12] == 3'b010) dec_w.op = OP_LW;
         7'b0100011: begin
            if (i_insn[14:12] == 3'b010) dec_w.op = OP_SW;
            dec_w.imm = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
         end
         default: dec_w.op = OP_ILLEGAL;
      endcase
   end

   assign last_bit  = (cnt_q == 5'd31);
   assign is_mem    = (dec_q.op == OP_LW) || (dec_q.op == OP_SW);
   assign is_reg_op = dec_q.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_WAIT_INSN: if (i_insn_valid) state_d = ST_DECODE;
         ST_DECODE:    state_d = ST_EXEC;
         ST_EXEC:      if (last_bit) state_d = is_mem ? ST_MEM : ST_RETIRE;
         ST_MEM: begin
            if (i_lsu_done) state_d = (dec_q.op == OP_LW) ? ST_LOAD_WB : ST_RETIRE;
         end
         ST_LOAD_WB:   if (last_bit) state_d = ST_RETIRE;
         ST_RETIRE:    state_d = i_insn_valid ? ST_DECODE : ST_WAIT_INSN;
         default:      state_d = ST_WAIT_INSN;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= ST_WAIT_INSN;
         cnt_q   <= 5'd0;
         go_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         go_q    <= (state_q == ST_EXEC) && last_bit && is_mem;
         // Wraps back to zero after 32 bits
         if (o_exec || o_load_wb) begin
            cnt_q <= cnt_q + 5'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (o_insn_take) begin
         dec_q <= dec_w;
      end
   end

   assign o_insn_take      = (state_q == ST_DECODE);
   assign o_dec            = dec_q;
   assign o_cnt            = cnt_q;
   assign o_exec           = (state_q == ST_EXEC);
   assign o_load_wb        = (state_q == ST_LOAD_WB);
   assign o_mem_go         = go_q;
   assign o_opb_bit        = is_reg_op ? i_rs2_bit : dec_q.imm[cnt_q];
   assign o_retire         = (state_q == ST_RETIRE);
   assign o_retire_illegal = o_retire && (dec_q.op == OP_ILLEGAL);

   // No rd write for x0, stores and illegal words
   assign o_rd_wen = (dec_q.rd != 5'd0) &&
                     ((o_exec && !(dec_q.op inside {OP_LW, OP_SW, OP_ILLEGAL})) ||
                      (o_load_wb && (dec_q.op == OP_LW)));

   // Counter rests at zero outside the serial phases
   assert property (@(posedge clk) disable iff (!i_rst_n)
      !(state_q inside {ST_EXEC, ST_LOAD_WB}) |-> (cnt_q == 5'd0));

endmodule

`default_nettype wire

// File: design/serial_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module serial_fetch
   import serial_pkg::*;
#(
   parameter logic [31:0] RESET_PC = 32'd0
) (
   input  wire         clk,
   input  wire         i_rst_n,
   input  wire         i_take,
   input  wire         i_rsp_vld,
   input  wire mem_rsp_t i_rsp,
   output logic        o_req_vld,
   output mem_req_t    o_req,
   output logic [31:0] o_insn,
   output logic        o_insn_valid,
   output logic [31:0] o_pc
);

   logic [31:0] nxt_q;   // Address of the word buffered or in flight
   logic [31:0] pc_q;
   logic [31:0] insn_q;
   logic        valid_q;
   logic        started_q;
   logic        boot_q;

   // Boot fetch once, then one sequential prefetch per take
   always_comb begin
      o_req_vld   = boot_q || i_take;
      o_req.addr  = i_take ? nxt_q[31:2] + 30'd1 : nxt_q[31:2];
      o_req.we    = 1'b0;
      o_req.wdata = 32'd0;
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         nxt_q     <= RESET_PC;
         pc_q      <= RESET_PC;
         valid_q   <= 1'b0;
         started_q <= 1'b0;
         boot_q    <= 1'b0;
      end else begin
         started_q <= 1'b1;
         boot_q    <= !started_q;
         if (i_take) begin
            pc_q    <= nxt_q;
            nxt_q   <= nxt_q + 32'd4;
            valid_q <= 1'b0;
         end
         if (i_rsp_vld) begin
            valid_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rsp_vld) begin
         insn_q <= i_rsp.rdata;
      end
   end

   assign o_insn       = insn_q;
   assign o_insn_valid = valid_q;
   assign o_pc         = pc_q;

   assert property (@(posedge clk) disable iff (!i_rst_n) i_rsp_vld |-> !valid_q);

endmodule

`default_nettype wire

// File: design/serial_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module serial_lsu
   import serial_pkg::*;
(
   input  wire           clk,
   input  wire           i_rst_n,
   input  wire [4:0]     i_cnt,
   input  wire           i_exec,
   input  wire           i_go,
   input  wire dec_t     i_dec,
   input  wire           i_alu_bit,
   input  wire           i_rs2_bit,
   input  wire           i_rsp_vld,
   input  wire mem_rsp_t i_rsp,
   output logic          o_req_vld,
   output mem_req_t      o_req,
   output logic          o_load_bit,
   output logic          o_done
);

   logic [31:0] addr_q;
   logic [31:0] wdata_q;
   logic [31:0] rdata_q;
   logic        busy_q;
   logic        is_mem;

   assign is_mem = (i_dec.op == OP_LW) || (i_dec.op == OP_SW);

   // LSB first, so after 32 bits the word sits in place
   always_ff @(posedge clk) begin
      if (i_exec && is_mem) begin
         addr_q <= {i_alu_bit, addr_q[31:1]};
      end
      if (i_exec && (i_dec.op == OP_SW)) begin
         wdata_q <= {i_rs2_bit, wdata_q[31:1]};
      end
      if (o_done && (i_dec.op == OP_LW)) begin
         rdata_q <= i_rsp.rdata;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy_q <= 1'b0;
      end else if (i_go) begin
         busy_q <= 1'b1;
      end else if (i_rsp_vld) begin
         busy_q <= 1'b0;
      end
   end

   always_comb begin
      o_req_vld   = i_go;
      o_req.addr  = addr_q[31:2];
      o_req.we    = (i_dec.op == OP_SW);
      o_req.wdata = wdata_q;
   end

   assign o_done     = i_rsp_vld && busy_q;
   assign o_load_bit = rdata_q[i_cnt];

endmodule

`default_nettype wire

// File: design/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
   import serial_pkg::*;
(
   input  wire           clk,
   input  wire           i_rst_n,
   input  wire           i_fetch_vld,
   input  wire mem_req_t i_fetch_req,
   input  wire           i_lsu_vld,
   input  wire mem_req_t i_lsu_req,
   input  wire           i_mem_rsp_vld,
   input  wire mem_rsp_t i_mem_rsp,
   output logic          o_mem_req_vld,
   output mem_req_t      o_mem_req,
   output logic          o_fetch_rsp_vld,
   output logic          o_lsu_rsp_vld,
   output mem_rsp_t      o_rsp
);

   bus_owner_e owner_q;
   mem_req_t   pend_req_q;
   logic       pend_q;
   logic       busy_q;
   logic       grant_fetch;
   logic       grant_lsu;

   // Load/store wins, a losing fetch waits in the pending slot
   assign grant_lsu   = i_lsu_vld;
   assign grant_fetch = (i_fetch_vld || pend_q) && !busy_q && !i_lsu_vld;

   assign o_mem_req_vld = grant_lsu || grant_fetch;
   assign o_mem_req     = grant_lsu ? i_lsu_req : (pend_q ? pend_req_q : i_fetch_req);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy_q  <= 1'b0;
         pend_q  <= 1'b0;
         owner_q <= OWN_FETCH;
      end else begin
         if (o_mem_req_vld) begin
            busy_q  <= 1'b1;
            owner_q <= grant_lsu ? OWN_LSU : OWN_FETCH;
         end else if (i_mem_rsp_vld) begin
            busy_q <= 1'b0;
         end
         if (i_fetch_vld && !grant_fetch) begin
            pend_q <= 1'b1;
         end else if (grant_fetch) begin
            pend_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_fetch_vld && !grant_fetch) begin
         pend_req_q <= i_fetch_req;
      end
   end

   assign o_fetch_rsp_vld = i_mem_rsp_vld && (owner_q == OWN_FETCH);
   assign o_lsu_rsp_vld   = i_mem_rsp_vld && (owner_q == OWN_LSU);
   assign o_rsp           = i_mem_rsp;

   assert property (@(posedge clk) disable iff (!i_rst_n) i_mem_rsp_vld |-> busy_q);

endmodule

`default_nettype wire

// File: design/serial_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module serial_core_top
   import serial_pkg::*;
#(
   parameter logic [31:0] RESET_PC = 32'd0
) (
   input  wire           clk,
   input  wire           i_rst_n,
   input  wire           i_mem_rsp_vld,
   input  wire mem_rsp_t i_mem_rsp,
   output logic          o_mem_req_vld,
   output mem_req_t      o_mem_req,
   output logic          o_retire,
   output logic [31:0]   o_retire_pc,
   output logic          o_retire_illegal
);

   dec_t       dec;
   mem_req_t   fetch_req;
   mem_req_t   lsu_req;
   mem_rsp_t   rsp;
   logic [31:0] insn;
   logic [4:0] cnt;
   logic       insn_valid, insn_take;
   logic       exec, load_wb, mem_go, lsu_done;
   logic       opb_bit, rs1_bit, rs2_bit, alu_bit, load_bit, rd_wen;
   logic       fetch_req_vld, fetch_rsp_vld, lsu_req_vld, lsu_rsp_vld;

   // Write-back source for rd
   wire rd_wbit = load_wb ? load_bit : alu_bit;

   serial_ctrl u_ctrl (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_insn           (insn),
      .i_insn_valid     (insn_valid),
      .i_lsu_done       (lsu_done),
      .i_rs2_bit        (rs2_bit),
      .o_insn_take      (insn_take),
      .o_dec            (dec),
      .o_cnt            (cnt),
      .o_exec           (exec),
      .o_load_wb        (load_wb),
      .o_mem_go         (mem_go),
      .o_opb_bit        (opb_bit),
      .o_rd_wen         (rd_wen),
      .o_retire         (o_retire),
      .o_retire_illegal (o_retire_illegal)
   );

   serial_fetch #(.RESET_PC(RESET_PC)) u_fetch (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_take       (insn_take),
      .i_rsp_vld    (fetch_rsp_vld),
      .i_rsp        (rsp),
      .o_req_vld    (fetch_req_vld),
      .o_req        (fetch_req),
      .o_insn       (insn),
      .o_insn_valid (insn_valid),
      .o_pc         (o_retire_pc)
   );

   serial_lsu u_lsu (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_exec     (exec),
      .i_go       (mem_go),
      .i_dec      (dec),
      .i_alu_bit  (alu_bit),
      .i_rs2_bit  (rs2_bit),
      .i_rsp_vld  (lsu_rsp_vld),
      .i_rsp      (rsp),
      .o_req_vld  (lsu_req_vld),
      .o_req      (lsu_req),
      .o_load_bit (load_bit),
      .o_done     (lsu_done)
   );

   serial_alu u_alu (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_exec    (exec),
      .i_cnt     (cnt),
      .i_op      (dec.op),
      .i_rs1_bit (rs1_bit),
      .i_opb_bit (opb_bit),
      .o_rd_bit  (alu_bit)
   );

   serial_rf u_rf (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_cnt     (cnt),
      .i_rs1     (dec.rs1),
      .i_rs2     (dec.rs2),
      .i_rd      (dec.rd),
      .i_wen     (rd_wen),
      .i_wbit    (rd_wbit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   bus_arbiter u_arbiter (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_fetch_vld     (fetch_req_vld),
      .i_fetch_req     (fetch_req),
      .i_lsu_vld       (lsu_req_vld),
      .i_lsu_req       (lsu_req),
      .i_mem_rsp_vld   (i_mem_rsp_vld),
      .i_mem_rsp       (i_mem_rsp),
      .o_mem_req_vld   (o_mem_req_vld),
      .o_mem_req       (o_mem_req),
      .o_fetch_rsp_vld (fetch_rsp_vld),
      .o_lsu_rsp_vld   (lsu_rsp_vld),
      .o_rsp           (rsp)
   );

endmodule

`default_nettype wire

// File: dv/tb_serial_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_serial_core
   import serial_pkg::*;
();

   localparam int N_RAND  = 200;
   localparam int N_TOTAL = N_RAND + 7;
   localparam int K_ADD   = 0;
   localparam int K_SUB   = 1;
   localparam int K_AND   = 2;
   localparam int K_OR    = 3;
   localparam int K_XOR   = 4;
   localparam int K_ADDI  = 5;
   localparam int K_LW    = 6;
   localparam int K_SW    = 7;
   localparam int K_ILL   = 8;

   logic        clk;
   logic        rst_n;
   logic        mem_rsp_vld;
   mem_rsp_t    mem_rsp;
   logic        mem_req_vld;
   mem_req_t    mem_req;
   logic        retire;
   logic [31:0] retire_pc;
   logic        retire_illegal;

   logic [31:0] mem [1024];
   logic [31:0] model_mem [1024];
   logic [31:0] model_reg [8];
   logic [31:0] model_pc;
   int          kind [256];
   logic [4:0]  f_rd [256];
   logic [4:0]  f_rs1 [256];
   logic [4:0]  f_rs2 [256];
   logic [31:0] f_imm [256];

   mem_req_t    req_hold;
   logic        req_prev;
   logic        data_done;
   int          fetch_seen;
   int          retired;
   int          err_value;
   int          err_proto;

   serial_core_top #(.RESET_PC(32'd0)) u_serial_core_top (
      .clk              (clk),
      .i_rst_n          (rst_n),
      .i_mem_rsp_vld    (mem_rsp_vld),
      .i_mem_rsp        (mem_rsp),
      .o_mem_req_vld    (mem_req_vld),
      .o_mem_req        (mem_req),
      .o_retire         (retire),
      .o_retire_pc      (retire_pc),
      .o_retire_illegal (retire_illegal)
   );

   always #50 clk = !clk;

   function automatic logic [31:0] encode_insn(input int k, input logic [4:0] rd,
         input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
      logic [31:0] w;
      case (k)
         K_ADD:   w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
         K_SUB:   w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
         K_AND:   w = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
         K_OR:    w = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
         K_XOR:   w = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
         K_ADDI:  w = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
         K_LW:    w = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
         K_SW:    w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
         // Opcode 7f is not part of RV32I
         default: w = {imm[31:7], 7'b1111111};
      endcase
      return w;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
         input logic [31:0] act);
      err_value++;
      $display("FAIL %s expected %h actual %h at %0t", name, exp, act, $time);
   endtask

   task automatic build_program();
      int          pick;
      logic [31:0] r;
      for (int i = 0; i < N_TOTAL; i++) begin
         r = $urandom;
         pick = int'($urandom % 100);
         f_rd[i[7:0]]  = {2'b00, r[2:0]};
         f_rs1[i[7:0]] = {2'b00, r[5:3]};
         f_rs2[i[7:0]] = {2'b00, r[8:6]};
         f_imm[i[7:0]] = {{20{r[20]}}, r[20:9]};
         if (i < 7) begin
            // Seed x1 to x7 first
            kind[i[7:0]]  = K_ADDI;
            f_rd[i[7:0]]  = 5'(i + 1);
            f_rs1[i[7:0]] = 5'd0;
         end else if (i >= N_RAND) begin
            kind[i[7:0]]  = K_SW;
            f_rs1[i[7:0]] = 5'd0;
            f_rs2[i[7:0]] = 5'(i - N_RAND + 1);
            f_imm[i[7:0]] = 32'(1024 + 4 * (i - N_RAND));
         end else if (pick < 5) begin
            kind[i[7:0]]  = K_ILL;
            f_imm[i[7:0]] = $urandom;
         end else if (pick < 25) begin
            kind[i[7:0]] = K_ADDI;
         end else if (pick < 65) begin
            kind[i[7:0]] = K_ADD + pick % 5;
         end else begin
            kind[i[7:0]]  = (pick < 82) ? K_SW : K_LW;
            f_rs1[i[7:0]] = 5'd0;
            f_imm[i[7:0]] = 32'd1024 + {22'd0, r[28:21], 2'b00};
         end
      end
   endtask

   task automatic check_request();
      int          cur;
      logic [31:0] ea;
      cur = int'(model_pc >> 2);
      ea  = model_reg[f_rs1[cur[7:0]][2:0]] + f_imm[cur[7:0]];
      // The data access follows the prefetch of the next word
      if ((kind[cur[7:0]] == K_LW || kind[cur[7:0]] == K_SW) && !data_done &&
          fetch_seen == cur + 2) begin
         if (mem_req.addr !== ea[31:2]) begin
            report_mismatch("o_mem_req.addr", {2'b00, ea[31:2]}, {2'b00, mem_req.addr});
         end
         if (mem_req.we !== (kind[cur[7:0]] == K_SW)) begin
            report_mismatch("o_mem_req.we", {31'd0, kind[cur[7:0]] == K_SW}, {31'd0, mem_req.we});
         end
         if (kind[cur[7:0]] == K_SW &&
             mem_req.wdata !== model_reg[f_rs2[cur[7:0]][2:0]]) begin
            report_mismatch("o_mem_req.wdata", model_reg[f_rs2[cur[7:0]][2:0]], mem_req.wdata);
         end
         data_done = 1'b1;
      end else begin
         if (mem_req.addr !== 30'(fetch_seen)) begin
            report_mismatch("o_mem_req.addr", fetch_seen, {2'b00, mem_req.addr});
         end
         if (mem_req.we !== 1'b0) begin
            report_mismatch("o_mem_req.we", 32'd0, {31'd0, mem_req.we});
         end
         fetch_seen++;
      end
   endtask

   task automatic step_model();
      int          cur;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] ea;
      logic [31:0] res;
      cur = int'(model_pc >> 2);
      if (retire_pc !== model_pc) begin
         report_mismatch("o_retire_pc", model_pc, retire_pc);
      end
      if (retire_illegal !== (kind[cur[7:0]] == K_ILL)) begin
         report_mismatch("o_retire_illegal", {31'd0, kind[cur[7:0]] == K_ILL},
                         {31'd0, retire_illegal});
      end
      if ((kind[cur[7:0]] == K_LW || kind[cur[7:0]] == K_SW) && !data_done) begin
         err_proto++;
         $display("Memory instruction at pc %h retired without a data access", model_pc);
      end
      a   = model_reg[f_rs1[cur[7:0]][2:0]];
      b   = model_reg[f_rs2[cur[7:0]][2:0]];
      ea  = a + f_imm[cur[7:0]];
      res = 32'd0;
      case (kind[cur[7:0]])
         K_ADD:   res = a + b;
         K_SUB:   res = a - b;
         K_AND:   res = a & b;
         K_OR:    res = a | b;
         K_XOR:   res = a ^ b;
         K_ADDI:  res = ea;
         K_LW:    res = model_mem[ea[11:2]];
         default: res = 32'd0;
      endcase
      if (kind[cur[7:0]] == K_SW) begin
         model_mem[ea[11:2]] = b;
      end
      // x0 is never written
      if (kind[cur[7:0]] <= K_LW && f_rd[cur[7:0]] != 5'd0) begin
         model_reg[f_rd[cur[7:0]][2:0]] = res;
      end
      model_pc  = model_pc + 32'd4;
      data_done = 1'b0;
      retired++;
   endtask

   // Sample mid-cycle where DUT outputs are settled
   always @(negedge clk) begin
      if (!rst_n) begin
         if (mem_req_vld || retire) begin
            err_proto++;
            $display("Request or retire strobe active during reset at %0t", $time);
         end
      end else begin
         if (mem_req_vld && req_prev) begin
            err_proto++;
            $display("Request strobe while a response was outstanding at %0t", $time);
         end
         if (mem_req_vld) begin
            req_hold = mem_req;
            if (mem_req.addr >= 30'd1024) begin
               err_proto++;
               $display("Request address outside the memory at %0t", $time);
            end
            if (retired < N_TOTAL) begin
               check_request();
            end
         end
         if (retire && retired < N_TOTAL) begin
            step_model();
         end
      end
      req_prev = mem_req_vld && rst_n;
   end

   // Memory answers one cycle after each request
   always @(posedge clk) begin
      #1;
      mem_rsp_vld = 1'b0;
      if (req_prev) begin
         mem_rsp_vld   = 1'b1;
         mem_rsp.rdata = mem[req_hold.addr[9:0]];
         if (req_hold.we) begin
            mem[req_hold.addr[9:0]] = req_hold.wdata;
         end
      end
   end

   initial begin
      #(N_TOTAL * 100 * 100);
      $display("Timeout after %0d of %0d retired instructions", retired, N_TOTAL);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      void'($urandom(32'had253fae));
      clk         = 1'b0;
      rst_n       = 1'b0;
      mem_rsp_vld = 1'b0;
      mem_rsp     = '0;
      req_prev    = 1'b0;
      data_done   = 1'b0;
      fetch_seen  = 0;
      retired     = 0;
      err_value   = 0;
      err_proto   = 0;
      model_pc    = 32'd0;
      for (int a = 0; a < 1024; a++) begin
         mem[a[9:0]] = (32'(a) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
      end
      build_program();
      for (int i = 0; i < N_TOTAL; i++) begin
         mem[i[9:0]] = encode_insn(kind[i[7:0]], f_rd[i[7:0]], f_rs1[i[7:0]],
                                   f_rs2[i[7:0]], f_imm[i[7:0]]);
      end
      for (int a = 0; a < 1024; a++) begin
         model_mem[a[9:0]] = mem[a[9:0]];
      end
      for (int r = 0; r < 8; r++) begin
         model_reg[r[2:0]] = 32'd0;
      end
      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;
      while (retired < N_TOTAL) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      $display("Errors: %0d value, %0d protocol, %0d instructions retired",
               err_value, err_proto, retired);
      if (err_value == 0 && err_proto == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: serial_core_top.f
design/serial_pkg.sv
design/serial_alu.sv
design/serial_rf.sv
design/serial_ctrl.sv
design/serial_fetch.sv
design/serial_lsu.sv
design/bus_arbiter.sv
design/serial_core_top.sv
dv/tb_serial_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f serial_core_top.f \
   --top-module tb_serial_core -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qF '** PASS **' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
